//--- rv_ex.f
src/rv_ex_pkg.sv
src/rv_ex_operands.sv
src/rv_ex_alu.sv
src/rv_ex_branch.sv
src/rv_ex_commit.sv
src/rv_ex_top.sv
tests/rv_ex_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module rv_ex_tb -Mdir obj_dir -o rv_ex_sim -f rv_ex.f \
    > build.log 2>&1 || { echo "build error, see build.log"; exit 1; }

./obj_dir/rv_ex_sim > "$LOG" 2>&1 || { cat "$LOG"; echo "simulator exited with an error"; exit 1; }

cat "$LOG"

grep -q "sim failed" "$LOG" && { echo "result: FAIL"; exit 1; } || { echo "result: PASS"; exit 0; }

//--- tests/rv_ex_tb.sv
`timescale 1ns/1ps

module rv_ex_tb;

    import rv_ex_pkg::*;

    localparam int IADDR_BITS = 32;
    // reset 5, alu 40, branch 24, jumps 12, store 2, flush 2, stall 7, plus slack.
    localparam int TEST_CYCLES    = 100;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_stall;
    logic                  i_flush;
    logic                  i_valid;
    issue_t                i_issue;
    logic [IADDR_BITS-1:0] i_pc;
    logic [IADDR_BITS-1:0] i_pc_next;
    logic [IADDR_BITS-1:0] i_ret_addr;
    logic [XLEN-1:0]       i_reg1_data;
    logic [XLEN-1:0]       i_reg2_data;
    ex_result_t            wb;
    logic                  redirect;
    logic [IADDR_BITS-1:0] redirect_pc;

    logic [31:0] lfsr = 32'h6464;
    int          err_count;
    int          pass_count;
    int          fail_count;
    int          cycles;

    rv_ex_top #(.IADDR_SPACE_BITS(IADDR_BITS)) i_rv_ex_top
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_valid       (i_valid),
        .i_issue       (i_issue),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .i_ret_addr    (i_ret_addr),
        .i_reg1_data   (i_reg1_data),
        .i_reg2_data   (i_reg2_data),
        .o_wb          (wb),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    always #50 i_clk = ~i_clk;

    // ********************
    // helpers and models
    // ********************

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand32(output logic [31:0] v);
        int b;
        for (b = 0; b < 32; b++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_SLL:  r = a << b[4:0];
            ALU_SLT:  r = ((a ^ 32'h80000000) < (b ^ 32'h80000000)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = a >> b[4:0];
            ALU_SRA:  r = (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'd0);
            ALU_OR:   r = a | b;
            ALU_AND:  r = a & b;
            default:  r = 32'd0;
        endcase
        return r;
    endfunction

    // a signed order is the unsigned order with both sign bits flipped.
    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return (a ^ 32'h80000000) < (b ^ 32'h80000000);
            F3_BGE:  return (a ^ 32'h80000000) >= (b ^ 32'h80000000);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [2:0] cond_code(input int i);
        case (i)
            0:       return F3_BEQ;
            1:       return F3_BNE;
            2:       return F3_BLT;
            3:       return F3_BGE;
            4:       return F3_BLTU;
            default: return F3_BGEU;
        endcase
    endfunction

    function automatic issue_t make_issue(input ex_ctrl_t c, input logic [4:0] rd,
                                          input logic [31:0] imm_i, input logic [31:0] imm_j);
        issue_t iss;
        iss       = '0;
        iss.ctrl  = c;
        iss.rd    = rd;
        iss.imm_i = imm_i;
        iss.imm_j = imm_j;
        return iss;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start)
            pass_count++;
        else
            fail_count++;
        $display("test %s done, %0d mismatches", name, err_count - errs_at_start);
    endtask

    // issue on one falling edge, register data on the next, results after the second.
    task automatic run_insn(input issue_t iss, input logic [31:0] pc, input logic [31:0] pc_next,
                            input logic [31:0] ret_addr, input logic [31:0] r1,
                            input logic [31:0] r2, input logic flush);
        i_valid    = 1'b1;
        i_issue    = iss;
        i_pc       = pc;
        i_pc_next  = pc_next;
        i_ret_addr = ret_addr;
        i_flush    = flush;
        @(negedge i_clk);
        i_valid     = 1'b0;
        i_flush     = 1'b0;
        i_reg1_data = r1;
        i_reg2_data = r2;
        @(negedge i_clk);
    endtask

    // ********************
    // directed tests
    // ********************

    task automatic test_reset;
        int e0;
        e0 = err_count;
        check(32'(wb.valid), 32'd0, "wb valid after reset");
        check(32'(redirect), 32'd0, "redirect after reset");
        @(negedge i_clk);
        check(32'(wb.valid), 32'd0, "wb valid one cycle after reset");
        check(32'(redirect), 32'd0, "redirect one cycle after reset");
        report_test("reset", e0);
    endtask

    task automatic test_alu;
        int          e0;
        int          k;
        logic        imm;
        alu_op_e     op;
        ex_ctrl_t    c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] alt;
        logic [31:0] pc;
        string       what;
        e0 = err_count;
        for (k = 0; k < 20; k++)
        begin
            imm = (k >= 10);
            op  = alu_op_e'(4'(k % 10));
            if (!(imm && op == ALU_SUB))   // there is no subtract-immediate form.
            begin
                rand32(a);
                rand32(b);
                rand32(pc);
                alt         = ~b;   // the operand source that is not selected.
                pc          = pc & ~32'd3;
                c           = '0;
                c.alu_op    = op;
                c.reg_write = 1'b1;
                c.op2_src   = imm ? OP2_IMM_I : OP2_REG;
                run_insn(make_issue(c, 5'(k + 1), imm ? b : alt, alt), pc, pc + 32'd4,
                         32'd0, a, imm ? alt : b, 1'b0);
                what = $sformatf("%s%s", op.name(), imm ? " imm" : "");
                check(wb.value, alu_model(op, a, b), {what, " value"});
                check(32'(wb.rd), 32'(k + 1), {what, " rd"});
                check(32'(wb.reg_write), 32'd1, {what, " reg_write"});
                check(32'(redirect), 32'd0, {what, " redirect"});
            end
        end

        // pc-relative add in the manner of auipc.
        rand32(pc);
        rand32(b);
        pc          = pc & ~32'd3;
        c           = '0;
        c.alu_op    = ALU_ADD;
        c.op1_pc    = 1'b1;
        c.op2_src   = OP2_IMM_J;
        c.reg_write = 1'b1;
        run_insn(make_issue(c, 5'd21, ~b, b), pc, pc + 32'd4, 32'd0, ~pc, ~b, 1'b0);
        check(wb.value, pc + b, "pc add value");
        check(32'(wb.rd), 32'd21, "pc add rd");
        check(32'(redirect), 32'd0, "pc add redirect");
        report_test("alu", e0);
    endtask

    task automatic test_branch;
        int          e0;
        int          i;
        logic        taken;
        ex_ctrl_t    c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] imm;
        e0 = err_count;
        // equality tests get an equal and an unequal pair.
        // order tests get pairs of opposite sign, where signed and unsigned order disagree.
        for (i = 0; i < 12; i++)
        begin
            rand32(a);
            rand32(b);
            rand32(pc);
            rand32(imm);
            if (i < 4)
                b = (i % 2 == 0) ? a : a ^ {b[31:1], 1'b1};
            else
            begin
                a[31] = (i % 2 == 0);
                b[31] = (i % 2 != 0);
            end
            pc       = pc & ~32'd3;
            imm      = (imm & 32'h00000ffc) | 32'h00000100;
            c        = '0;
            c.branch = 1'b1;
            c.funct3 = cond_code(i / 2);
            taken    = branch_model(c.funct3, a, b);
            run_insn(make_issue(c, 5'd0, 32'd0, imm), pc, pc + 32'd4, 32'd0, a, b, 1'b0);
            check(32'(redirect), 32'(taken), "branch redirect");
            check(redirect_pc, taken ? pc + imm : pc + 32'd4, "branch next pc");
            check(32'(wb.reg_write), 32'd0, "branch reg_write");
        end
        report_test("branch", e0);
    endtask

    task automatic test_jumps;
        int          e0;
        int          kind;
        int          p;
        ex_ctrl_t    c;
        logic [31:0] pc;
        logic [31:0] r1;
        logic [31:0] imm;
        logic [31:0] imm_j;
        logic [31:0] ret;
        logic [31:0] target;
        e0 = err_count;
        for (kind = 0; kind < 3; kind++)
        begin
            for (p = 0; p < 2; p++)
            begin
                rand32(pc);
                rand32(r1);
                rand32(imm);
                rand32(ret);
                pc    = pc & ~32'd3;
                r1    = r1 | 32'd1;   // an odd sum shows that jalr clears bit 0.
                imm   = (imm & 32'h00000ffc) | 32'h00000100;
                imm_j = imm + 32'h00001000;
                ret   = ret & ~32'd3;
                c     = '0;
                if (kind == 2)
                begin
                    c.mret = 1'b1;
                    target = ret;
                end
                else
                begin
                    c.res_src   = RES_LINK;
                    c.reg_write = 1'b1;
                    c.jal       = (kind == 0);
                    c.jalr      = (kind == 1);
                    target      = (kind == 0) ? pc + imm_j : (r1 + imm) & ~32'd1;
                end
                run_insn(make_issue(c, 5'd1, imm, imm_j), pc, p ? target : pc + 32'd4, ret,
                         r1, 32'd0, 1'b0);
                check(32'(redirect), p ? 32'd0 : 32'd1, "jump redirect");
                if (p == 0)
                    check(redirect_pc, target, "jump target");
                if (kind < 2)
                    check(wb.value, pc + 32'd4, "link value");
                check(32'(wb.reg_write), (kind < 2) ? 32'd1 : 32'd0, "jump reg_write");
            end
        end
        report_test("jumps", e0);
    endtask

    task automatic test_store;
        int          e0;
        ex_ctrl_t    c;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] imm;
        e0 = err_count;
        rand32(r1);
        rand32(r2);
        rand32(imm);
        c         = '0;
        c.store   = 1'b1;
        c.alu_op  = ALU_ADD;
        c.op2_src = OP2_IMM_I;
        run_insn(make_issue(c, 5'd3, imm, 32'd0), 32'h100, 32'h104, 32'd0, r1, r2, 1'b0);
        check(32'(wb.store), 32'd1, "store flag");
        check(wb.store_data, r2, "store data");
        check(wb.value, r1 + imm, "store address");
        check(32'(wb.reg_write), 32'd0, "store reg_write");
        check(32'(redirect), 32'd0, "store redirect");
        report_test("store", e0);
    endtask

    task automatic test_flush;
        int       e0;
        ex_ctrl_t c;
        e0          = err_count;
        c           = '0;
        c.jal       = 1'b1;
        c.res_src   = RES_LINK;
        c.reg_write = 1'b1;
        run_insn(make_issue(c, 5'd4, 32'd0, 32'h400), 32'h200, 32'h204, 32'd0, 32'd0, 32'd0, 1'b1);
        check(32'(wb.valid), 32'd0, "flushed valid");
        check(32'(wb.reg_write), 32'd0, "flushed reg_write");
        check(32'(redirect), 32'd0, "flushed redirect");
        report_test("flush", e0);
    endtask

    task automatic test_stall;
        int          e0;
        int          k;
        ex_ctrl_t    c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_a;
        e0 = err_count;
        rand32(a);
        rand32(b);
        c           = '0;
        c.alu_op    = ALU_XOR;
        c.reg_write = 1'b1;
        run_insn(make_issue(c, 5'd5, 32'd0, 32'd0), 32'h300, 32'h304, 32'd0, a, b, 1'b0);
        exp_a = a ^ b;
        check(wb.value, exp_a, "value before stall");

        // the next instruction waits at the stage input while the stall holds.
        c.alu_op  = ALU_ADD;
        c.op2_src = OP2_IMM_I;
        i_valid   = 1'b1;
        i_issue   = make_issue(c, 5'd6, 32'h55, 32'd0);
        i_pc      = 32'h304;
        i_pc_next = 32'h308;
        i_stall   = 1'b1;
        for (k = 0; k < 3; k++)
        begin
            @(negedge i_clk);
            check(wb.value, exp_a, "held value");
            check(32'(wb.rd), 32'd5, "held rd");
            check(32'(wb.valid), 32'd1, "held valid");
            check(32'(redirect), 32'd0, "held redirect");
        end
        i_stall = 1'b0;
        @(negedge i_clk);
        i_valid     = 1'b0;
        i_reg1_data = b;
        @(negedge i_clk);
        check(wb.value, b + 32'h55, "value after stall");
        check(32'(wb.rd), 32'd6, "rd after stall");
        check(32'(wb.valid), 32'd1, "valid after stall");
        report_test("stall", e0);
    endtask

    // ********************
    // run control
    // ********************

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        i_clk       = 1'b0;
        i_rst_n     = 1'b0;
        i_stall     = 1'b0;
        i_flush     = 1'b0;
        i_valid     = 1'b0;
        i_issue     = '0;
        i_pc        = '0;
        i_pc_next   = '0;
        i_ret_addr  = '0;
        i_reg1_data = '0;
        i_reg2_data = '0;
        err_count   = 0;
        pass_count  = 0;
        fail_count  = 0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        test_reset();
        test_alu();
        test_branch();
        test_jumps();
        test_store();
        test_flush();
        test_stall();

        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- src/rv_ex_top.sv
`timescale 1ns/1ps

module rv_ex_top
#(
    parameter int IADDR_SPACE_BITS = rv_ex_pkg::IADDR_DEFAULT
)
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic                        i_valid,
    input  rv_ex_pkg::issue_t           i_issue,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc_next,
    input  logic [IADDR_SPACE_BITS-1:0] i_ret_addr,
    input  logic [rv_ex_pkg::XLEN-1:0]  i_reg1_data,
    input  logic [rv_ex_pkg::XLEN-1:0]  i_reg2_data,
    output rv_ex_pkg::ex_result_t       o_wb,
    output logic                        o_redirect,
    output logic [IADDR_SPACE_BITS-1:0] o_redirect_pc
);

    import rv_ex_pkg::*;

    logic                        valid;
    ex_ctrl_t                    ctrl;
    logic [4:0]                  rd;
    logic [XLEN-1:0]             op1;
    logic [XLEN-1:0]             op2;
    logic [IADDR_SPACE_BITS-1:0] pc;
    logic [IADDR_SPACE_BITS-1:0] pc_next;
    logic [IADDR_SPACE_BITS-1:0] pc_target;
    logic [XLEN-1:0]             reg_data1;
    logic [XLEN-1:0]             reg_data2;
    logic [XLEN-1:0]             alu_result;
    logic                        redirect_req;
    logic [IADDR_SPACE_BITS-1:0] next_pc;

    rv_ex_operands #(.IADDR_SPACE_BITS(IADDR_SPACE_BITS)) i_rv_ex_operands
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_valid        (i_valid),
        .i_issue        (i_issue),
        .i_pc           (i_pc),
        .i_pc_next      (i_pc_next),
        .i_ret_addr     (i_ret_addr),
        .i_reg1_data    (i_reg1_data),
        .i_reg2_data    (i_reg2_data),
        .o_valid        (valid),
        .o_ctrl         (ctrl),
        .o_rd           (rd),
        .o_op1          (op1),
        .o_op2          (op2),
        .o_pc           (pc),
        .o_pc_next      (pc_next),
        .o_pc_target    (pc_target),
        .o_reg_data1    (reg_data1),
        .o_reg_data2    (reg_data2)
    );

    // the ALU and the branch resolver work side by side on the latched instruction.
    rv_ex_alu i_rv_ex_alu
    (
        .i_op1          (op1),
        .i_op2          (op2),
        .i_alu_op       (ctrl.alu_op),
        .o_result       (alu_result)
    );

    rv_ex_branch #(.IADDR_SPACE_BITS(IADDR_SPACE_BITS)) i_rv_ex_branch
    (
        .i_valid        (valid),
        .i_ctrl         (ctrl),
        .i_reg_data1    (reg_data1),
        .i_reg_data2    (reg_data2),
        .i_pc           (pc),
        .i_pc_next      (pc_next),
        .i_pc_target    (pc_target),
        .o_next_pc      (next_pc),
        .o_redirect_req (redirect_req)
    );

    rv_ex_commit #(.IADDR_SPACE_BITS(IADDR_SPACE_BITS)) i_rv_ex_commit
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (i_stall),
        .i_valid        (valid),
        .i_ctrl         (ctrl),
        .i_rd           (rd),
        .i_pc           (pc),
        .i_alu_result   (alu_result),
        .i_store_data   (reg_data2),
        .i_redirect_req (redirect_req),
        .i_next_pc      (next_pc),
        .o_wb           (o_wb),
        .o_redirect     (o_redirect),
        .o_redirect_pc  (o_redirect_pc)
    );

endmodule

//--- src/rv_ex_commit.sv
`timescale 1ns/1ps

module rv_ex_commit
#(
    parameter int IADDR_SPACE_BITS = rv_ex_pkg::IADDR_DEFAULT
)
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_valid,
    input  rv_ex_pkg::ex_ctrl_t         i_ctrl,
    input  logic [4:0]                  i_rd,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc,
    input  logic [rv_ex_pkg::XLEN-1:0]  i_alu_result,
    input  logic [rv_ex_pkg::XLEN-1:0]  i_store_data,
    input  logic                        i_redirect_req,
    input  logic [IADDR_SPACE_BITS-1:0] i_next_pc,
    output rv_ex_pkg::ex_result_t       o_wb,
    output logic                        o_redirect,
    output logic [IADDR_SPACE_BITS-1:0] o_redirect_pc
);

    import rv_ex_pkg::*;

    logic [IADDR_SPACE_BITS-1:0] link_pc;
    logic [XLEN-1:0]             value;

    logic                        wb_valid;
    logic                        wb_reg_write;
    logic                        wb_store;
    logic                        redirect;
    logic [4:0]                  wb_rd;
    logic [XLEN-1:0]             wb_value;
    logic [XLEN-1:0]             wb_store_data;
    logic [IADDR_SPACE_BITS-1:0] redirect_pc;

    assign link_pc = i_pc + IADDR_SPACE_BITS'(INSN_BYTES);
    assign value   = (i_ctrl.res_src == RES_LINK) ? XLEN'(link_pc) : i_alu_result;

    // ********************
    // writeback register
    // ********************

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_store     <= 1'b0;
            redirect     <= 1'b0;
        end
        else if (!i_stall)
        begin
            wb_valid     <= i_valid;
            wb_reg_write <= i_valid & i_ctrl.reg_write;   // a bubble must not write.
            wb_store     <= i_valid & i_ctrl.store;
            redirect     <= i_redirect_req;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            wb_rd         <= i_rd;
            wb_value      <= value;
            wb_store_data <= i_store_data;
            redirect_pc   <= i_next_pc;
        end
    end

    assign o_wb.valid      = wb_valid;
    assign o_wb.reg_write  = wb_reg_write;
    assign o_wb.rd         = wb_rd;
    assign o_wb.value      = wb_value;
    assign o_wb.store      = wb_store;
    assign o_wb.store_data = wb_store_data;

    assign o_redirect    = redirect;
    assign o_redirect_pc = redirect_pc;

endmodule

//--- src/rv_ex_branch.sv
`timescale 1ns/1ps

module rv_ex_branch
#(
    parameter int IADDR_SPACE_BITS = rv_ex_pkg::IADDR_DEFAULT
)
(
    input  logic                        i_valid,
    input  rv_ex_pkg::ex_ctrl_t         i_ctrl,
    input  logic [rv_ex_pkg::XLEN-1:0]  i_reg_data1,
    input  logic [rv_ex_pkg::XLEN-1:0]  i_reg_data2,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc_next,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc_target,
    output logic [IADDR_SPACE_BITS-1:0] o_next_pc,
    output logic                        o_redirect_req
);

    import rv_ex_pkg::*;

    logic                        cond;
    logic                        taken;
    logic [IADDR_SPACE_BITS-1:0] pc_seq;
    logic [IADDR_SPACE_BITS-1:0] next_pc;

    always_comb
    begin
        case (i_ctrl.funct3)
            F3_BEQ:  cond = i_reg_data1 == i_reg_data2;
            F3_BNE:  cond = i_reg_data1 != i_reg_data2;
            F3_BLT:  cond = $signed(i_reg_data1) < $signed(i_reg_data2);
            F3_BGE:  cond = $signed(i_reg_data1) >= $signed(i_reg_data2);
            F3_BLTU: cond = i_reg_data1 < i_reg_data2;
            F3_BGEU: cond = i_reg_data1 >= i_reg_data2;
            default: cond = 1'b0;   // reserved encodings never branch.
        endcase
    end

    // jumps and mret always leave the sequential path.
    assign taken = i_ctrl.jal | i_ctrl.jalr | i_ctrl.mret | (i_ctrl.branch & cond);

    assign pc_seq  = i_pc + IADDR_SPACE_BITS'(INSN_BYTES);
    assign next_pc = taken ? i_pc_target : pc_seq;

    // a wrong prediction shows up as a mismatch against the fetched successor.
    assign o_redirect_req = i_valid & (next_pc != i_pc_next);
    assign o_next_pc      = next_pc;

endmodule

//--- src/rv_ex_alu.sv
`timescale 1ns/1ps

module rv_ex_alu
(
    input  logic [rv_ex_pkg::XLEN-1:0] i_op1,
    input  logic [rv_ex_pkg::XLEN-1:0] i_op2,
    input  rv_ex_pkg::alu_op_e         i_alu_op,
    output logic [rv_ex_pkg::XLEN-1:0] o_result
);

    import rv_ex_pkg::*;

    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] result;

    assign shamt       = i_op2[4:0];   // only the low five bits count in RV32I.
    assign lt_signed   = $signed(i_op1) < $signed(i_op2);
    assign lt_unsigned = i_op1 < i_op2;

    always_comb
    begin
        case (i_alu_op)
            ALU_ADD:
            begin
                result = i_op1 + i_op2;
            end
            ALU_SUB:
            begin
                result = i_op1 - i_op2;
            end
            ALU_SLL:
            begin
                result = i_op1 << shamt;
            end
            ALU_SLT:
            begin
                result = XLEN'(lt_signed);
            end
            ALU_SLTU:
            begin
                result = XLEN'(lt_unsigned);
            end
            ALU_XOR:
            begin
                result = i_op1 ^ i_op2;
            end
            ALU_SRL:
            begin
                result = i_op1 >> shamt;
            end
            ALU_SRA:
            begin
                result = $unsigned($signed(i_op1) >>> shamt);   // sign bit fills from the left.
            end
            ALU_OR:
            begin
                result = i_op1 | i_op2;
            end
            ALU_AND:
            begin
                result = i_op1 & i_op2;
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

    assign o_result = result;

endmodule

//--- src/rv_ex_operands.sv
`timescale 1ns/1ps

module rv_ex_operands
#(
    parameter int IADDR_SPACE_BITS = rv_ex_pkg::IADDR_DEFAULT
)
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_stall,
    input  logic                          i_flush,
    input  logic                          i_valid,
    input  rv_ex_pkg::issue_t             i_issue,
    input  logic [IADDR_SPACE_BITS-1:0]   i_pc,
    input  logic [IADDR_SPACE_BITS-1:0]   i_pc_next,
    input  logic [IADDR_SPACE_BITS-1:0]   i_ret_addr,
    input  logic [rv_ex_pkg::XLEN-1:0]    i_reg1_data,
    input  logic [rv_ex_pkg::XLEN-1:0]    i_reg2_data,
    output logic                          o_valid,
    output rv_ex_pkg::ex_ctrl_t           o_ctrl,
    output logic [4:0]                    o_rd,
    output logic [rv_ex_pkg::XLEN-1:0]    o_op1,
    output logic [rv_ex_pkg::XLEN-1:0]    o_op2,
    output logic [IADDR_SPACE_BITS-1:0]   o_pc,
    output logic [IADDR_SPACE_BITS-1:0]   o_pc_next,
    output logic [IADDR_SPACE_BITS-1:0]   o_pc_target,
    output logic [rv_ex_pkg::XLEN-1:0]    o_reg_data1,
    output logic [rv_ex_pkg::XLEN-1:0]    o_reg_data2
);

    import rv_ex_pkg::*;

    logic                        valid;
    ex_ctrl_t                    ctrl;
    logic [4:0]                  rd;
    logic [XLEN-1:0]             imm_i;
    logic [XLEN-1:0]             imm_j;
    logic [IADDR_SPACE_BITS-1:0] pc;
    logic [IADDR_SPACE_BITS-1:0] pc_next;

    logic [XLEN-1:0]             pc_ext;
    logic [XLEN-1:0]             op2;
    logic [IADDR_SPACE_BITS-1:0] target_base;
    logic [IADDR_SPACE_BITS-1:0] target_offset;
    logic [IADDR_SPACE_BITS-1:0] target_sum;

    // ********************
    // stage register
    // ********************

    // flush wins over stall so a killed instruction never lingers in the stage.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            valid <= 1'b0;
            ctrl  <= '0;
        end
        else if (i_flush)
        begin
            valid <= 1'b0;
            ctrl  <= '0;
        end
        else if (!i_stall)
        begin
            valid <= i_valid;
            ctrl  <= i_issue.ctrl;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            rd      <= i_issue.rd;
            imm_i   <= i_issue.imm_i;
            imm_j   <= i_issue.imm_j;
            pc      <= i_pc;
            pc_next <= i_pc_next;   // predicted successor, checked by the branch resolver.
        end
    end

    // ********************
    // operand selection
    // ********************

    assign pc_ext = XLEN'(pc);

    assign o_op1 = ctrl.op1_pc ? pc_ext : i_reg1_data;

    always_comb
    begin
        case (ctrl.op2_src)
            OP2_IMM_I: op2 = imm_i;
            OP2_IMM_J: op2 = imm_j;
            default:   op2 = i_reg2_data;
        endcase
    end

    assign o_op2 = op2;

    // ********************
    // target address
    // ********************

    assign target_base   = ctrl.mret ? i_ret_addr :
                           ctrl.jalr ? i_reg1_data[IADDR_SPACE_BITS-1:0] :
                           pc;
    assign target_offset = ctrl.mret ? '0 :
                           ctrl.jalr ? imm_i[IADDR_SPACE_BITS-1:0] :
                           imm_j[IADDR_SPACE_BITS-1:0];
    assign target_sum    = target_base + target_offset;

    // jalr drops bit 0 of the computed address.
    assign o_pc_target = ctrl.jalr ? {target_sum[IADDR_SPACE_BITS-1:1], 1'b0} : target_sum;

    assign o_valid     = valid;
    assign o_ctrl      = ctrl;
    assign o_rd        = rd;
    assign o_pc        = pc;
    assign o_pc_next   = pc_next;
    assign o_reg_data1 = i_reg1_data;
    assign o_reg_data2 = i_reg2_data;

endmodule

//--- src/rv_ex_pkg.sv
package rv_ex_pkg;

    // ********************
    // widths and constants
    // ********************

    localparam int XLEN          = 32;
    localparam int IADDR_DEFAULT = 32;   // instruction address width unless the top overrides it.
    localparam int INSN_BYTES    = 4;    // every RV32I instruction is one word.

    // branch conditions as encoded in funct3.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ********************
    // control encodings
    // ********************

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        OP2_REG   = 2'd0,
        OP2_IMM_I = 2'd1,
        OP2_IMM_J = 2'd2
    } op2_src_e;

    // the link value is the address of the following instruction.
    typedef enum logic {
        RES_ALU  = 1'b0,
        RES_LINK = 1'b1
    } res_src_e;

    // ********************
    // records
    // ********************

    typedef struct packed {
        alu_op_e    alu_op;
        logic       op1_pc;      // operand 1 is the pc instead of register 1.
        op2_src_e   op2_src;
        res_src_e   res_src;
        logic       reg_write;
        logic       store;
        logic       jal;
        logic       jalr;
        logic       branch;
        logic       mret;
        logic [2:0] funct3;
    } ex_ctrl_t;

    typedef struct packed {
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_j;
        ex_ctrl_t        ctrl;
    } issue_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        logic            store;
        logic [XLEN-1:0] store_data;
    } ex_result_t;

endpackage
